//--- include/mem2_settings.svh
`ifndef MEM2_SETTINGS_SVH
`define MEM2_SETTINGS_SVH

////////////////////
// Memory geometry
////////////////////

// Address and word widths
`define MEM2_ADDR_W 15
`define MEM2_WORD_W 18

// Address split into bank and in-bank offset
`define MEM2_BANK_W 5
`define MEM2_OFFSET_W 10

////////////////////
// Self-test sweep
////////////////////

// Banks covered by the test
`define MEM2_BANKS 30
// Fibonacci sums written per bank, last one is 46368
`define MEM2_FIB_TERMS 23

`endif

//--- logic/mem2_pkg.sv
`include "mem2_settings.svh"

package mem2_pkg;

	// Full memory address
	typedef logic [`MEM2_ADDR_W-1:0] addr_t;

	// Stored word
	typedef logic [`MEM2_WORD_W-1:0] word_t;

	// Upper address field
	typedef logic [`MEM2_BANK_W-1:0] bank_t;

	// Index of a sum within one bank
	typedef logic [4:0] term_t;

	// Self-test sequencer states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FILL,
		ST_VERIFY,
		ST_DRAIN
	} selftest_state_t;

endpackage

//--- logic/dual_port_ram.sv
`timescale 1ns/1ns

`include "mem2_settings.svh"

module dual_port_ram import mem2_pkg::*; (
	input  logic  clk,
	input  logic  w0,
	input  logic  w1,
	input  addr_t addr0,
	input  addr_t addr1,
	input  word_t data0,
	input  word_t data1,
	output word_t out0,
	output word_t out1
);

	// Every address decoded
	localparam int DEPTH = 1 << `MEM2_ADDR_W;

	////////////////////
	// Storage
	////////////////////

	word_t mem [DEPTH];

	// Both write ports in one process
	// Port 1 assigned last, so it wins a same-address collision
	always_ff @(posedge clk) begin
		if (w0) begin
			mem[addr0] <= data0;
		end
		if (w1) begin
			mem[addr1] <= data1;
		end
	end

	////////////////////
	// Registered reads
	////////////////////

	// Old contents on a read during write
	always_ff @(posedge clk) begin
		out0 <= mem[addr0];
		out1 <= mem[addr1];
	end

endmodule

//--- logic/sweep_counter.sv
`timescale 1ns/1ns

`include "mem2_settings.svh"

module sweep_counter import mem2_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  clear,
	input  logic  step,
	output bank_t bank,
	output term_t term,
	output logic  last
);

	// Final indices of the sweep
	localparam term_t TERM_MAX = term_t'(`MEM2_FIB_TERMS - 1);
	localparam bank_t BANK_MAX = bank_t'(`MEM2_BANKS - 1);

	logic term_wrap;

	// Term about to roll over to zero
	assign term_wrap = (term == TERM_MAX);

	// Last step of the whole sweep
	assign last = term_wrap && (bank == BANK_MAX);

	////////////////////
	// Counters
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			term <= '0;
			bank <= '0;
		end else if (clear) begin
			// Clear wins over step
			term <= '0;
			bank <= '0;
		end else if (step) begin
			if (term_wrap) begin
				term <= '0;
				// Bank advances on each term wrap
				bank <= (bank == BANK_MAX) ? '0 : bank + 1'b1;
			end else begin
				term <= term + 1'b1;
			end
		end
	end

endmodule

//--- logic/fib_pattern_gen.sv
`timescale 1ns/1ns

`include "mem2_settings.svh"

module fib_pattern_gen import mem2_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  clear,
	input  logic  step,
	input  term_t term,
	output word_t value
);

	// Current term is the last one of a bank
	localparam term_t TERM_MAX = term_t'(`MEM2_FIB_TERMS - 1);

	// Two previous terms of the sequence
	word_t fib_a;
	word_t fib_b;
	logic restart;

	// Counter wraps to term zero on this step
	assign restart = step && (term == TERM_MAX);

	// Presented sum, 1 for the starting pair
	assign value = fib_a + fib_b;

	////////////////////
	// Sequence state
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fib_a <= '0;
			fib_b <= word_t'(1);
		end else if (clear || restart) begin
			// Starting pair 0, 1
			fib_a <= '0;
			fib_b <= word_t'(1);
		end else if (step) begin
			// Shift the pair along by one
			fib_a <= fib_b;
			fib_b <= value;
		end
	end

endmodule

//--- logic/readback_checker.sv
`timescale 1ns/1ns

module readback_checker import mem2_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  clear,
	input  logic  compare,
	input  word_t expected,
	input  addr_t addr,
	input  word_t readback,
	output logic  fail,
	output addr_t fail_addr
);

	logic  compare_q;
	word_t expected_q;
	addr_t addr_q;
	logic  mismatch;

	////////////////////
	// Read latency match
	////////////////////

	// Compare strobe, one cycle behind the read address
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			compare_q <= 1'b0;
		end else begin
			compare_q <= compare && !clear;
		end
	end

	// Expected word and its address, same delay
	always_ff @(posedge clk) begin
		expected_q <= expected;
		addr_q     <= addr;
	end

	// RAM output now lines up with the delayed pair
	assign mismatch = compare_q && (readback != expected_q);

	////////////////////
	// Sticky result
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fail <= 1'b0;
		end else if (clear) begin
			fail <= 1'b0;
		end else if (mismatch) begin
			fail <= 1'b1;
		end
	end

	// First failing address only
	always_ff @(posedge clk) begin
		if (mismatch && !fail) begin
			fail_addr <= addr_q;
		end
	end

endmodule

//--- logic/selftest_fsm.sv
`timescale 1ns/1ns

`include "mem2_settings.svh"

module selftest_fsm import mem2_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  start,
	input  logic  last,
	input  bank_t bank,
	input  word_t value,
	input  logic  w1,
	input  addr_t addr1,
	input  word_t data1,
	output logic  ram_w1,
	output addr_t ram_addr1,
	output word_t ram_data1,
	output logic  cnt_clear,
	output logic  cnt_step,
	output logic  gen_clear,
	output logic  gen_step,
	output logic  chk_clear,
	output logic  chk_compare,
	output addr_t chk_addr,
	output logic  busy,
	output logic  done
);

	selftest_state_t state;
	selftest_state_t state_next;
	logic  start_ok;
	logic  sweeping;
	addr_t eng_addr;

	////////////////////
	// State register
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			done  <= 1'b0;
		end else begin
			state <= state_next;
			// Pulse on the edge back to idle
			done  <= (state == ST_DRAIN);
		end
	end

	// Next state
	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE:   if (start) state_next = ST_FILL;
			ST_FILL:   if (last) state_next = ST_VERIFY;
			ST_VERIFY: if (last) state_next = ST_DRAIN;
			ST_DRAIN:  state_next = ST_IDLE;
			default:   state_next = ST_IDLE;
		endcase
	end

	////////////////////
	// Engine controls
	////////////////////

	// Start only taken from idle
	assign start_ok = (state == ST_IDLE) && start;
	assign busy     = (state != ST_IDLE);
	assign sweeping = (state == ST_FILL) || (state == ST_VERIFY);

	// Fresh sweep at start and again entering verify
	assign cnt_clear = start_ok || ((state == ST_FILL) && last);
	assign gen_clear = cnt_clear;
	assign cnt_step  = sweeping;
	assign gen_step  = sweeping;

	// Result cleared by an accepted start only
	assign chk_clear   = start_ok;
	assign chk_compare = (state == ST_VERIFY);

	// Bank in the upper bits, low bits of the sum below
	assign eng_addr = {bank, value[`MEM2_OFFSET_W-1:0]};
	assign chk_addr = eng_addr;

	////////////////////
	// Port 1 mux
	////////////////////

	// Engine owns port 1 while busy, writes only in fill
	assign ram_w1    = busy ? (state == ST_FILL) : w1;
	assign ram_addr1 = busy ? eng_addr : addr1;
	assign ram_data1 = busy ? value : data1;

endmodule

//--- logic/mem2_top.sv
`timescale 1ns/1ns

module mem2_top import mem2_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	// Instruction port
	input  logic  w0,
	input  addr_t addr0,
	input  word_t data0,
	output word_t out0,
	// Data port
	input  logic  w1,
	input  addr_t addr1,
	input  word_t data1,
	output word_t out1,
	// Self-test
	input  logic  start,
	output logic  busy,
	output logic  done,
	output logic  fail,
	output addr_t fail_addr
);

	// Port 1 after the engine mux
	logic  ram_w1;
	addr_t ram_addr1;
	word_t ram_data1;

	// Engine controls
	logic  cnt_clear;
	logic  cnt_step;
	logic  gen_clear;
	logic  gen_step;
	logic  chk_clear;
	logic  chk_compare;
	addr_t chk_addr;

	// Sweep position and pattern
	bank_t bank;
	term_t term;
	logic  last;
	word_t fib_value;

	////////////////////
	// Memory
	////////////////////

	dual_port_ram u_ram (
		.clk   (clk),
		.w0    (w0),
		.w1    (ram_w1),
		.addr0 (addr0),
		.addr1 (ram_addr1),
		.data0 (data0),
		.data1 (ram_data1),
		.out0  (out0),
		.out1  (out1)
	);

	////////////////////
	// Test engine
	////////////////////

	sweep_counter u_cnt (
		.clk    (clk),
		.arst_n (arst_n),
		.clear  (cnt_clear),
		.step   (cnt_step),
		.bank   (bank),
		.term   (term),
		.last   (last)
	);

	fib_pattern_gen u_gen (
		.clk    (clk),
		.arst_n (arst_n),
		.clear  (gen_clear),
		.step   (gen_step),
		.term   (term),
		.value  (fib_value)
	);

	// Expected word is the generator output
	readback_checker u_chk (
		.clk       (clk),
		.arst_n    (arst_n),
		.clear     (chk_clear),
		.compare   (chk_compare),
		.expected  (fib_value),
		.addr      (chk_addr),
		.readback  (out1),
		.fail      (fail),
		.fail_addr (fail_addr)
	);

	selftest_fsm u_fsm (
		.clk         (clk),
		.arst_n      (arst_n),
		.start       (start),
		.last        (last),
		.bank        (bank),
		.value       (fib_value),
		.w1          (w1),
		.addr1       (addr1),
		.data1       (data1),
		.ram_w1      (ram_w1),
		.ram_addr1   (ram_addr1),
		.ram_data1   (ram_data1),
		.cnt_clear   (cnt_clear),
		.cnt_step    (cnt_step),
		.gen_clear   (gen_clear),
		.gen_step    (gen_step),
		.chk_clear   (chk_clear),
		.chk_compare (chk_compare),
		.chk_addr    (chk_addr),
		.busy        (busy),
		.done        (done)
	);

endmodule

//--- verification/mem2_properties.sv
`timescale 1ns/1ns

module mem2_properties (
	input logic clk,
	input logic arst_n,
	input logic busy,
	input logic done,
	input logic fail
);

	////////////////////
	// Handshake
	////////////////////

	// Done marks the return to idle
	done_not_busy: assert property (@(posedge clk) disable iff (!arst_n) !(done && busy))
		else $error("done and busy high in the same cycle");

	// Engine idle coming out of reset
	idle_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !busy)
		else $error("busy high right after reset");

	////////////////////
	// Result flag
	////////////////////

	// Only an accepted start clears fail
	fail_sticky: assert property (@(posedge clk) disable iff (!arst_n) $fell(fail) |-> busy)
		else $error("fail dropped while the engine was idle");

endmodule

// Checker on every mem2_top
bind mem2_top mem2_properties u_props (
	.clk    (clk),
	.arst_n (arst_n),
	.busy   (busy),
	.done   (done),
	.fail   (fail)
);

//--- verification/mem2_tb.sv
`timescale 1ns/1ns

`include "mem2_settings.svh"

module mem2_tb import mem2_pkg::*; ();

	// Half period of the 20 ns clock
	localparam int CLK_HALF = 10;
	// Inputs change this long after a rising edge
	localparam int DRIVE_DELAY = 2;
	// Both sweeps plus the drain cycle
	localparam int SELFTEST_CYCLES = 2 * `MEM2_BANKS * `MEM2_FIB_TERMS + 1;
	// Generous margin over the self-test length
	localparam int DONE_TIMEOUT = 3000;
	// Random writes per port test
	localparam int RW_COUNT = 16;

	logic  clk;
	logic  arst_n;
	logic  w0;
	addr_t addr0;
	word_t data0;
	word_t out0;
	logic  w1;
	addr_t addr1;
	word_t data1;
	word_t out1;
	logic  start;
	logic  busy;
	logic  done;
	logic  fail;
	addr_t fail_addr;

	// LFSR state
	logic [31:0] lfsr;
	// Memory model for the port tests
	word_t model [addr_t];
	addr_t used_addr [RW_COUNT];

	mem2_top u_dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.w0        (w0),
		.addr0     (addr0),
		.data0     (data0),
		.out0      (out0),
		.w1        (w1),
		.addr1     (addr1),
		.data1     (data1),
		.out1      (out1),
		.start     (start),
		.busy      (busy),
		.done      (done),
		.fail      (fail),
		.fail_addr (fail_addr)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	////////////////////
	// Helpers
	////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic next_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] random_bits(input int width);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < width; i++) begin
			r = {r[30:0], next_bit()};
		end
		return r;
	endfunction

	// Edge then settle into the drive slot
	task automatic tick();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic abort_run();
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
			abort_run();
		end
	endtask

	// Busy follows the start pulse on the next edge
	task automatic start_selftest();
		start = 1'b1;
		tick();
		start = 1'b0;
		check_value("busy", 32'(busy), 32'd1);
	endtask

	// Optionally throws random port-1 writes at the DUT while waiting
	task automatic wait_done(input logic disturb);
		int  cycles;
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < DONE_TIMEOUT) begin
			tick();
			cycles++;
			if (done) begin
				seen = 1'b1;
			end else if (disturb) begin
				w1    = 1'(random_bits(1));
				addr1 = addr_t'(random_bits(`MEM2_ADDR_W));
				data1 = word_t'(random_bits(`MEM2_WORD_W));
			end
		end
		w1 = 1'b0;
		if (!seen) begin
			$display("timeout: self-test never pulsed done");
			abort_run();
		end
		check_value("busy", 32'(busy), 32'd0);
		check_value("done latency", 32'(cycles), 32'(SELFTEST_CYCLES));
		// Done lasts a single cycle
		tick();
		check_value("done", 32'(done), 32'd0);
	endtask

	// Read every sum back on port 1 against sums built here
	task automatic verify_fib_contents();
		word_t a;
		word_t b;
		word_t s;
		for (int bk = 0; bk < `MEM2_BANKS; bk++) begin
			a = '0;
			b = word_t'(1);
			for (int t = 0; t < `MEM2_FIB_TERMS; t++) begin
				s = a + b;
				addr1 = {bank_t'(bk), s[`MEM2_OFFSET_W-1:0]};
				tick();
				check_value("out1", 32'(out1), 32'(s));
				a = b;
				b = s;
			end
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	// Random writes then read-back on port 0 or port 1
	task automatic test_port_rw(input logic port);
		addr_t a;
		word_t d;
		for (int i = 0; i < RW_COUNT; i++) begin
			a = addr_t'(random_bits(`MEM2_ADDR_W));
			d = word_t'(random_bits(`MEM2_WORD_W));
			used_addr[i] = a;
			model[a] = d;
			if (port) begin
				{w1, addr1, data1} = {1'b1, a, d};
			end else begin
				{w0, addr0, data0} = {1'b1, a, d};
			end
			tick();
		end
		w0 = 1'b0;
		w1 = 1'b0;
		for (int i = 0; i < RW_COUNT; i++) begin
			if (port) begin
				addr1 = used_addr[i];
				tick();
				check_value("out1", 32'(out1), 32'(model[used_addr[i]]));
			end else begin
				addr0 = used_addr[i];
				tick();
				check_value("out0", 32'(out0), 32'(model[used_addr[i]]));
			end
		end
	endtask

	// Both ports hit one address in one cycle and port 1 data sticks
	task automatic test_collision();
		addr_t a;
		word_t d1;
		a  = addr_t'(random_bits(`MEM2_ADDR_W));
		d1 = word_t'(random_bits(`MEM2_WORD_W));
		{w0, addr0, data0} = {1'b1, a, ~d1};
		{w1, addr1, data1} = {1'b1, a, d1};
		tick();
		w0 = 1'b0;
		w1 = 1'b0;
		tick();
		check_value("out0", 32'(out0), 32'(d1));
		check_value("out1", 32'(out1), 32'(d1));
	endtask

	task automatic test_clean_selftest();
		start_selftest();
		wait_done(1'b0);
		check_value("fail", 32'(fail), 32'd0);
		verify_fib_contents();
	endtask

	// Port 0 keeps zeroing bank 0 term 0 during the whole run
	task automatic test_fault_detect();
		{w0, addr0, data0} = {1'b1, 15'h001, 18'h0};
		start_selftest();
		wait_done(1'b0);
		w0 = 1'b0;
		check_value("fail", 32'(fail), 32'd1);
		check_value("fail_addr", 32'(fail_addr), 32'h001);
	endtask

	// Restart clears the old fail while outside port-1 traffic is ignored
	task automatic test_busy_gating();
		check_value("fail", 32'(fail), 32'd1);
		start_selftest();
		check_value("fail", 32'(fail), 32'd0);
		wait_done(1'b1);
		check_value("fail", 32'(fail), 32'd0);
		verify_fib_contents();
	endtask

	////////////////////
	// Sequence
	////////////////////

	initial begin
		lfsr   = 32'hf672;
		arst_n = 1'b0;
		{w0, addr0, data0} = '0;
		{w1, addr1, data1} = '0;
		start  = 1'b0;
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		arst_n = 1'b1;
		tick();
		check_value("busy", 32'(busy), 32'd0);
		test_port_rw(1'b0);
		test_port_rw(1'b1);
		test_collision();
		test_clean_selftest();
		test_fault_detect();
		test_busy_gating();
		$display("No errors");
		$finish;
	end

endmodule

//--- mem2_top.f
+incdir+include
logic/mem2_pkg.sv
logic/dual_port_ram.sv
logic/sweep_counter.sv
logic/fib_pattern_gen.sv
logic/readback_checker.sv
logic/selftest_fsm.sv
logic/mem2_top.sv
verification/mem2_properties.sv
verification/mem2_tb.sv

//--- Makefile
# Verilator flow for the mem2 testbench

VERILATOR ?= verilator
TOP       ?= mem2_tb
FILELIST  ?= mem2_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status of the simulation is the test result
sim: build
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
